//--- filelist.f
+incdir+hdl
hdl/debugPkg.sv
hdl/msgFifo.sv
hdl/serialLink.sv
hdl/msgDeframer.sv
hdl/cmdExecutor.sv
hdl/msgFramer.sv
hdl/debugTop.sv
tb/debugTb.sv

//--- hdl/cmdExecutor.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module cmdExecutor
    import debugPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  debugMsg_t  inMsg,
    input  logic       inReady,
    input  logic       replyNotFull,
    output logic       inPop,
    output debugMsg_t  reply,
    output logic       replyPush,
    output logic [3:0] led
);
    localparam int AddrW = $clog2(`SCRATCH_DEPTH);

    execState_t       state;
    logic [7:0]       scratch [`SCRATCH_DEPTH];
    logic [AddrW-1:0] addr;
    logic             needsReply;
    debugMsg_t        replyNext;

    // Address wraps modulo the scratch depth
    assign addr       = inMsg.payload[0][AddrW-1:0];
    assign needsReply = (inMsg.msgType == ReadMem) || (inMsg.msgType == Echo);

    // Reply contents for the head message
    always_comb begin
        replyNext = inMsg;
        if (inMsg.payloadLen > 8'(`MSG_MAX_PAYLOAD_LEN)) begin
            replyNext.payloadLen = 8'(`MSG_MAX_PAYLOAD_LEN);
        end
        if (inMsg.msgType == ReadMem) begin
            replyNext.payloadLen = 8'd1;
            replyNext.payload    = '0;
            replyNext.payload[0] = scratch[addr];
        end
    end

    // ========================================
    // Execute FSM
    // ========================================
    // ExDone gives the queues a cycle to update after each pop and push
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ExIdle;
            inPop     <= 1'b0;
            replyPush <= 1'b0;
            led       <= '0;
            for (int i = 0; i < `SCRATCH_DEPTH; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            inPop     <= 1'b0;
            replyPush <= 1'b0;
            case (state)
                ExIdle: begin
                    if (inReady && needsReply && !replyNotFull) begin
                        state <= ExStall;
                    end else if (inReady) begin
                        inPop     <= 1'b1;
                        replyPush <= needsReply;
                        state     <= ExDone;
                        if (inMsg.msgType == SetLed) begin
                            led <= inMsg.payload[0][3:0];
                        end
                        if (inMsg.msgType == WriteMem) begin
                            scratch[addr] <= inMsg.payload[1];
                        end
                    end
                end
                ExStall: begin
                    if (replyNotFull) begin
                        inPop     <= 1'b1;
                        replyPush <= 1'b1;
                        state     <= ExDone;
                    end
                end
                default: begin
                    state <= ExIdle;
                end
            endcase
        end
    end

    // Held steady through ExDone while replyPush is high
    always_ff @(posedge clk) begin
        if (state != ExDone) begin
            reply <= replyNext;
        end
    end

endmodule

//--- hdl/debugPkg.sv
`include "debug_settings.svh"

package debugPkg;

    // Message type byte, zero doubles as the idle filler
    typedef enum logic [7:0] {
        Nop      = 8'd0,
        SetLed   = 8'd1,
        WriteMem = 8'd2,
        ReadMem  = 8'd3,
        Echo     = 8'd4
    } msgType_t;

    // One framed message; payload[0] is the first payload byte on the wire
    typedef struct packed {
        msgType_t                             msgType;
        logic [7:0]                           payloadLen;
        logic [`MSG_MAX_PAYLOAD_LEN-1:0][7:0] payload;
    } debugMsg_t;

    // Receive side framing
    typedef enum logic [1:0] {
        DfType,
        DfLength,
        DfPayload
    } deframeState_t;

    // Reply serialization
    typedef enum logic [1:0] {
        FrType,
        FrLength,
        FrPayload
    } frameState_t;

    // Command execution
    typedef enum logic [1:0] {
        ExIdle,
        ExDone,
        ExStall
    } execState_t;

endpackage

//--- hdl/debugTop.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module debugTop
    import debugPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [3:0] led
);
    logic [7:0] rxByte;
    logic       rxStrobe;
    logic       csActive;
    debugMsg_t  rxMsg;
    logic       rxMsgPush;
    debugMsg_t  inHead;
    logic       inReady;
    logic       inPop;
    debugMsg_t  reply;
    logic       replyPush;
    debugMsg_t  replyHead;
    logic       replyReady;
    logic       replyNotFull;
    logic       replyPop;
    logic [7:0] txByte;
    logic       txPush;
    logic [7:0] byteHead;
    logic       byteReady;
    logic       byteNotFull;
    logic       txPop;

    // ========================================
    // Receive path
    // ========================================
    serialLink link (
        .clk(clk), .rst(rst),
        .debugClk(debugClk), .debugCs(debugCs), .debugDi(debugDi), .debugDo(debugDo),
        .rxByte(rxByte), .rxStrobe(rxStrobe), .csActive(csActive),
        .txByte(byteHead), .txReady(byteReady), .txPop(txPop)
    );

    msgDeframer deframer (
        .clk(clk), .rst(rst),
        .rxByte(rxByte), .rxStrobe(rxStrobe), .csActive(csActive),
        .msg(rxMsg), .msgPush(rxMsgPush)
    );

    // Overflow is not reported back to the host
    msgFifo #(.Width($bits(debugMsg_t)), .Depth(`IN_QUEUE_DEPTH)) inQueue (
        .clk(clk), .rst(rst),
        .push(rxMsgPush), .pushData(rxMsg), .pop(inPop),
        .popData(inHead), .ready(inReady), .notFull()
    );

    cmdExecutor executor (
        .clk(clk), .rst(rst),
        .inMsg(inHead), .inReady(inReady), .replyNotFull(replyNotFull),
        .inPop(inPop), .reply(reply), .replyPush(replyPush), .led(led)
    );

    // ========================================
    // Reply path
    // ========================================
    msgFifo #(.Width($bits(debugMsg_t)), .Depth(`REPLY_QUEUE_DEPTH)) replyQueue (
        .clk(clk), .rst(rst),
        .push(replyPush), .pushData(reply), .pop(replyPop),
        .popData(replyHead), .ready(replyReady), .notFull(replyNotFull)
    );

    msgFramer framer (
        .clk(clk), .rst(rst),
        .reply(replyHead), .replyReady(replyReady), .byteNotFull(byteNotFull),
        .replyPop(replyPop), .txByte(txByte), .txPush(txPush)
    );

    msgFifo #(.Width(8), .Depth(`BYTE_QUEUE_DEPTH)) byteQueue (
        .clk(clk), .rst(rst),
        .push(txPush), .pushData(txByte), .pop(txPop),
        .popData(byteHead), .ready(byteReady), .notFull(byteNotFull)
    );

endmodule

//--- hdl/debug_settings.svh
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

// Payload bytes stored per message
`define MSG_MAX_PAYLOAD_LEN 5

// Queue depths in entries (powers of two)
`define IN_QUEUE_DEPTH 4
`define REPLY_QUEUE_DEPTH 4
`define BYTE_QUEUE_DEPTH 16

// Scratch memory entries
`define SCRATCH_DEPTH 16

// Flip-flops per synchronizer chain on the serial inputs
`define SYNC_STAGES 2

`endif

//--- hdl/msgDeframer.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module msgDeframer
    import debugPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rxByte,
    input  logic       rxStrobe,
    input  logic       csActive,
    output debugMsg_t  msg,
    output logic       msgPush
);
    deframeState_t state;
    logic [7:0]    payloadCount;
    logic          lastPayload;

    assign lastPayload = (payloadCount == (msg.payloadLen - 8'd1));

    // ========================================
    // Framing control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || !csActive) begin
            state        <= DfType;
            payloadCount <= '0;
            msgPush      <= 1'b0;
        end else begin
            msgPush <= 1'b0;
            if (rxStrobe) begin
                case (state)
                    DfType: begin
                        // Zero bytes are idle filler, so a frame may begin on any byte
                        if (rxByte != 8'h00) begin
                            state <= DfLength;
                        end
                    end
                    DfLength: begin
                        payloadCount <= '0;
                        if (rxByte == 8'h00) begin
                            msgPush <= 1'b1;
                            state   <= DfType;
                        end else begin
                            state <= DfPayload;
                        end
                    end
                    DfPayload: begin
                        // Every payload byte is counted even once storage is full
                        payloadCount <= payloadCount + 8'd1;
                        if (lastPayload) begin
                            msgPush <= 1'b1;
                            state   <= DfType;
                        end
                    end
                    default: begin
                        state <= DfType;
                    end
                endcase
            end
        end
    end

    // ========================================
    // Message assembly
    // ========================================
    always_ff @(posedge clk) begin
        if (csActive && rxStrobe) begin
            case (state)
                DfType: begin
                    if (rxByte != 8'h00) begin
                        msg.msgType <= msgType_t'(rxByte);
                        msg.payload <= '0;
                    end
                end
                DfLength: begin
                    msg.payloadLen <= rxByte;
                end
                DfPayload: begin
                    for (int i = 0; i < `MSG_MAX_PAYLOAD_LEN; i++) begin
                        if (payloadCount == 8'(i)) begin
                            msg.payload[i] <= rxByte;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- hdl/msgFifo.sv
`timescale 1ns/1ns

module msgFifo #(
    parameter int Width = 8,
    parameter int Depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    input  logic             pop,
    output logic [Width-1:0] popData,
    output logic             ready,
    output logic             notFull
);
    localparam int PtrW = $clog2(Depth);

    logic [Width-1:0] mem [Depth];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [PtrW:0]    count;
    logic             doPush;
    logic             doPop;

    // Push while full and pop while empty are dropped here
    assign doPush = push && notFull;
    assign doPop  = pop && ready;

    assign ready   = (count != '0);
    assign notFull = (count != (PtrW+1)'(Depth));
    // Head entry is valid whenever ready is high
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/msgFramer.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module msgFramer
    import debugPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  debugMsg_t  reply,
    input  logic       replyReady,
    input  logic       byteNotFull,
    output logic       replyPop,
    output logic [7:0] txByte,
    output logic       txPush
);
    localparam int IdxW = $clog2(`MSG_MAX_PAYLOAD_LEN);

    frameState_t     state;
    logic [IdxW-1:0] idx;
    logic            lastByte;

    // ========================================
    // Byte select and handshake
    // ========================================
    // Push is decided in the same cycle as the queue's notFull level
    always_comb begin
        txByte   = 8'h00;
        txPush   = 1'b0;
        lastByte = 1'b0;
        case (state)
            FrType: begin
                txByte = reply.msgType;
                txPush = replyReady && byteNotFull;
            end
            FrLength: begin
                txByte   = reply.payloadLen;
                txPush   = byteNotFull;
                lastByte = (reply.payloadLen == 8'd0);
            end
            FrPayload: begin
                txByte   = reply.payload[idx];
                txPush   = byteNotFull;
                lastByte = (8'(idx) == (reply.payloadLen - 8'd1));
            end
            default: begin
            end
        endcase
    end

    // Reply leaves the queue with its final byte
    assign replyPop = txPush && lastByte;

    // ========================================
    // Frame FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FrType;
            idx   <= '0;
        end else if (txPush) begin
            case (state)
                FrType: begin
                    state <= FrLength;
                end
                FrLength: begin
                    idx   <= '0;
                    state <= lastByte ? FrType : FrPayload;
                end
                FrPayload: begin
                    idx <= idx + 1'b1;
                    if (lastByte) begin
                        state <= FrType;
                    end
                end
                default: begin
                    state <= FrType;
                end
            endcase
        end
    end

endmodule

//--- hdl/serialLink.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module serialLink (
    input  logic       clk,
    input  logic       rst,
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [7:0] rxByte,
    output logic       rxStrobe,
    output logic       csActive,
    input  logic [7:0] txByte,
    input  logic       txReady,
    output logic       txPop
);
    logic [`SYNC_STAGES-1:0] clkSync;
    logic [`SYNC_STAGES-1:0] csSync;
    logic [`SYNC_STAGES-1:0] diSync;
    logic                    sclk;
    logic                    sdi;
    logic                    sclkPrev;
    logic                    csPrev;
    logic                    riseEdge;
    logic                    fallEdge;
    logic                    csStart;
    logic [8:0]              rxShift;
    logic [8:0]              rxNext;
    logic [8:0]              txShift;
    logic                    txLoad;

    // ========================================
    // Input synchronizers and edge detect
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            clkSync  <= '0;
            csSync   <= '0;
            diSync   <= '0;
            sclkPrev <= 1'b0;
            csPrev   <= 1'b0;
        end else begin
            clkSync  <= {clkSync[`SYNC_STAGES-2:0], debugClk};
            csSync   <= {csSync[`SYNC_STAGES-2:0], debugCs};
            diSync   <= {diSync[`SYNC_STAGES-2:0], debugDi};
            sclkPrev <= sclk;
            csPrev   <= csActive;
        end
    end

    assign sclk     = clkSync[`SYNC_STAGES-1];
    assign sdi      = diSync[`SYNC_STAGES-1];
    assign csActive = csSync[`SYNC_STAGES-1];
    assign riseEdge = csActive && sclk && !sclkPrev;
    assign fallEdge = csActive && !sclk && sclkPrev;
    assign csStart  = csActive && !csPrev;

    // ========================================
    // Receive shifter
    // ========================================
    // Sentinel starts in bit 0 and reaches bit 8 after eight data bits
    assign rxNext = {rxShift[7:0], sdi};

    always_ff @(posedge clk) begin
        if (rst || !csActive) begin
            rxShift  <= 9'd1;
            rxStrobe <= 1'b0;
        end else begin
            rxStrobe <= 1'b0;
            if (riseEdge) begin
                if (rxNext[8]) begin
                    rxByte   <= rxNext[7:0];
                    rxStrobe <= 1'b1;
                    rxShift  <= 9'd1;
                end else begin
                    rxShift <= rxNext;
                end
            end
        end
    end

    // ========================================
    // Transmit shifter
    // ========================================
    // Trailing sentinel in bit 0; when it reaches bit 7 the last data bit is on debugDo
    assign txLoad  = csStart || (fallEdge && (txShift[7:0] == 8'h80));
    assign txPop   = txLoad && txReady;
    assign debugDo = txShift[8];

    always_ff @(posedge clk) begin
        if (rst || !csActive) begin
            txShift <= '0;
        end else if (txLoad) begin
            // Zero byte fills the gap when nothing is queued
            txShift <= {(txReady ? txByte : 8'h00), 1'b1};
        end else if (fallEdge) begin
            txShift <= txShift << 1;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile and run the debug port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module debugTb -f filelist.f -o debugSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/debugSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/debugTb.sv
`timescale 1ns/1ns
`include "debug_settings.svh"

module debugTb
    import debugPkg::*;
();
    // Frame bytes over all behaviors, and one serial byte in ns (8 bits of 8 clk cycles)
    localparam int FrameBytes = 264;
    localparam int ByteNs     = 8 * 8 * 40;
    localparam int TimeoutNs  = FrameBytes * ByteNs * 3 + 200000;

    logic       clk;
    logic       rst;
    logic       debugClk;
    logic       debugCs;
    logic       debugDi;
    logic       debugDo;
    logic [3:0] led;

    logic [31:0] lcgState = 32'h7587;
    logic [7:0]  payloadBuf [8];
    logic [7:0]  txBytes [$];
    logic [7:0]  rxBytes [$];
    debugMsg_t   expQ [$];
    debugMsg_t   gotQ [$];
    logic [3:0]  modelLed;
    logic [7:0]  modelMem [`SCRATCH_DEPTH];
    int          replyBytes;
    int          errors;
    int          checked;
    event        windowDone;

    debugTop i_dut (
        .clk(clk), .rst(rst),
        .debugClk(debugClk), .debugCs(debugCs), .debugDi(debugDi),
        .debugDo(debugDo), .led(led)
    );

    always #20 clk = ~clk;

    function automatic logic [7:0] randByte();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[23:16];
    endfunction

    // ========================================
    // Reference model
    // ========================================
    // Updates the model LED and memory, returns the expected reply (type Nop if none)
    function automatic debugMsg_t refExecute(input logic [7:0] typ, input logic [7:0] len);
        debugMsg_t exp;
        int        n;
        exp = '0;
        n   = (len > 8'd`MSG_MAX_PAYLOAD_LEN) ? `MSG_MAX_PAYLOAD_LEN : int'(len);
        case (typ)
            SetLed: modelLed = payloadBuf[0][3:0];
            WriteMem: modelMem[payloadBuf[0] % `SCRATCH_DEPTH] = payloadBuf[1];
            ReadMem: begin
                exp.msgType    = ReadMem;
                exp.payloadLen = 8'd1;
                exp.payload[0] = modelMem[payloadBuf[0] % `SCRATCH_DEPTH];
            end
            Echo: begin
                exp.msgType    = Echo;
                exp.payloadLen = 8'(n);
                for (int i = 0; i < n; i++) begin
                    exp.payload[i] = payloadBuf[i];
                end
            end
            default: begin
            end
        endcase
        return exp;
    endfunction

    // ========================================
    // Host side helpers
    // ========================================
    task automatic fillPayload(input int len);
        for (int i = 0; i < len; i++) begin
            payloadBuf[i] = randByte();
        end
    endtask

    task automatic addIdle(input int count);
        for (int i = 0; i < count; i++) begin
            txBytes.push_back(8'h00);
        end
    endtask

    task automatic addFrame(input msgType_t typ, input int len);
        debugMsg_t exp;
        txBytes.push_back(typ);
        txBytes.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            txBytes.push_back(payloadBuf[i]);
        end
        exp = refExecute(typ, 8'(len));
        if (exp.msgType != Nop) begin
            expQ.push_back(exp);
            replyBytes += 2 + int'(exp.payloadLen);
        end
    endtask

    // One chip-select window; cutBits > 0 drops chip select inside the last byte
    task automatic runWindow(input int cutBits);
        int         nBytes;
        int         nBits;
        logic [7:0] txb;
        logic [7:0] rxb;
        rxb = 8'h00;
        if (cutBits == 0) begin
            addIdle(replyBytes + 4);
        end
        replyBytes = 0;
        nBytes     = txBytes.size();
        debugCs    = 1'b1;
        for (int i = 0; i < nBytes; i++) begin
            txb   = txBytes.pop_front();
            nBits = (cutBits > 0 && i == nBytes - 1) ? cutBits : 8;
            for (int b = 0; b < nBits; b++) begin
                debugDi = txb[7-b];
                repeat (4) @(negedge clk);
                debugClk = 1'b1;
                rxb      = {rxb[6:0], debugDo};
                repeat (4) @(negedge clk);
                debugClk = 1'b0;
                // Final fall and chip-select drop land together, so no byte is popped
                if (i == nBytes - 1 && b == nBits - 1) begin
                    debugCs = 1'b0;
                end
            end
            if (nBits == 8) begin
                rxBytes.push_back(rxb);
            end
        end
        debugDi = 1'b0;
        repeat (8) @(negedge clk);
        ->windowDone;
        @(negedge clk);
    endtask

    // ========================================
    // Reply parsing and comparison
    // ========================================
    task automatic parseReplies();
        debugMsg_t  msg;
        logic [7:0] b;
        bit         done;
        done = 1'b0;
        while (!done) begin
            while (rxBytes.size() > 0 && rxBytes[0] == 8'h00) begin
                void'(rxBytes.pop_front());
            end
            if (rxBytes.size() < 2 || rxBytes.size() < 2 + int'(rxBytes[1])) begin
                done = 1'b1;
            end else begin
                msg            = '0;
                msg.msgType    = msgType_t'(rxBytes.pop_front());
                msg.payloadLen = rxBytes.pop_front();
                for (int i = 0; i < int'(msg.payloadLen); i++) begin
                    b = rxBytes.pop_front();
                    if (i < `MSG_MAX_PAYLOAD_LEN) begin
                        msg.payload[i] = b;
                    end
                end
                gotQ.push_back(msg);
            end
        end
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                  input logic [63:0] gotVal);
        errors++;
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expVal, gotVal);
    endtask

    initial begin : compareReplies
        debugMsg_t got;
        debugMsg_t exp;
        forever begin
            @(windowDone);
            parseReplies();
            while (gotQ.size() > 0) begin
                got = gotQ.pop_front();
                assert (expQ.size() > 0) else begin
                    errors++;
                    $display("%0t ns: got a reply of type %0d that no command asked for",
                             $time, got.msgType);
                end
                if (expQ.size() > 0) begin
                    exp = expQ.pop_front();
                    checked++;
                    assert (got.msgType == exp.msgType)
                        else reportMismatch("reply.msgType", exp.msgType, got.msgType);
                    assert (got.payloadLen == exp.payloadLen)
                        else reportMismatch("reply.payloadLen", exp.payloadLen, got.payloadLen);
                    assert (got.payload == exp.payload)
                        else reportMismatch("reply.payload", exp.payload, got.payload);
                end
            end
            assert (expQ.size() == 0) else begin
                errors++;
                $display("%0t ns: %0d expected replies never arrived", $time, expQ.size());
                expQ.delete();
            end
            assert (led == modelLed) else reportMismatch("led", modelLed, led);
        end
    end

    initial begin : watchdog
        #(TimeoutNs);
        errors++;
        $display("timeout: run still busy after %0d ns", TimeoutNs);
        $display("errors: %0d, replies checked: %0d", errors, checked);
        $display("test failed");
        $finish;
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin : stimulus
        logic [7:0] addr;
        clk        = 1'b0;
        rst        = 1'b1;
        debugClk   = 1'b0;
        debugCs    = 1'b0;
        debugDi    = 1'b0;
        modelLed   = '0;
        replyBytes = 0;
        errors     = 0;
        checked    = 0;
        for (int i = 0; i < `SCRATCH_DEPTH; i++) begin
            modelMem[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // LED writes, no replies
        for (int n = 0; n < 6; n++) begin
            fillPayload(1);
            addFrame(SetLed, 1);
        end
        runWindow(0);

        // Writes and reads, even passes read back the address just written
        for (int n = 0; n < 20; n++) begin
            fillPayload(2);
            addFrame(WriteMem, 2);
            if (n % 2 == 1) begin
                payloadBuf[0] = randByte();
            end
            addFrame(ReadMem, 1);
        end
        runWindow(0);

        for (int len = 0; len <= 5; len++) begin
            fillPayload(len);
            addFrame(Echo, len);
        end
        runWindow(0);

        // Oversized echo followed by a normal one
        fillPayload(8);
        addFrame(Echo, 8);
        fillPayload(2);
        addFrame(Echo, 2);
        runWindow(0);

        // Idle bytes between frames
        addIdle(3);
        fillPayload(1);
        addFrame(SetLed, 1);
        addIdle(2);
        fillPayload(2);
        addFrame(WriteMem, 2);
        addIdle(2);
        runWindow(0);

        // Interrupted write must leave memory untouched
        addr = randByte();
        txBytes.push_back(WriteMem);
        txBytes.push_back(8'd2);
        txBytes.push_back(addr);
        txBytes.push_back(~modelMem[addr % `SCRATCH_DEPTH]);
        runWindow(3);

        payloadBuf[0] = addr;
        addFrame(ReadMem, 1);
        fillPayload(1);
        addFrame(SetLed, 1);
        fillPayload(3);
        addFrame(Echo, 3);
        runWindow(0);

        // Back-to-back reads
        for (int n = 0; n < 12; n++) begin
            payloadBuf[0] = randByte();
            addFrame(ReadMem, 1);
        end
        runWindow(0);

        $display("errors: %0d, replies checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
